// ==== bench/bdReadoutInput.txt ====
1 281234567 0 01234567 1
1 29abcdef1 1 0abcdef1 1
1 2bf00ff00 2 1f00ff00 1
1 2e0000001 3 00000001 1
1 2ffffffff 4 0fffffff 1
1 2d5a5a5a5 5 05a5a5a5 1
1 23c0ffee0 6 3c0ffee0 1
1 252345678 7 12345678 1
1 3deadbeef 8 deadbeef 1
1 2c0000010 9 00000010 1
1 2cfabcdef a 07abcdef 1
1 180000001 b 80000001 1
1 0ffffffff c ffffffff 1
1 0a5a5a5a5 c a5a5a5a5 1
3 2c0000020 9 00000020 0
3 290000002 1 00000002 1
3 2c7ffffff 9 07ffffff 0
3 2c8000001 a 00000001 0
4 000000001 c 00000001 1
4 280000003 0 00000003 1
4 1ffff0000 b ffff0000 1
4 300000004 8 00000004 1
4 200000005 6 00000005 1
4 2a0000006 2 00000006 1
4 012345678 c 12345678 1
4 2d0000007 5 00000007 1
4 3fffffffe 8 fffffffe 1
4 240000008 7 00000008 1
4 100000009 b 00000009 1
4 2f000000a 4 0000000a 1

// ==== sim.f ====
verilog/bdPkg.sv
verilog/bdDecoder.sv
verilog/tagWriter.sv
verilog/diagWriter.sv
verilog/logArbiter.sv
verilog/logFifo.sv
verilog/bdReadout.sv
bench/clockGen.sv
bench/bdReadoutTb.sv

// ==== Bender.yml ====
package:
  name: bd_readout

sources:
  - verilog/bdPkg.sv
  - verilog/bdDecoder.sv
  - verilog/tagWriter.sv
  - verilog/diagWriter.sv
  - verilog/logArbiter.sv
  - verilog/logFifo.sv
  - verilog/bdReadout.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/bdReadoutTb.sv

// ==== bench/bdReadoutTb.sv ====
`timescale 1ns/1ps

module bdReadoutTb;
  import bdPkg::*;

  // leaf codes by number
  localparam logic [3:0] codeNrni = 4'd8;
  localparam logic [3:0] codeOvflw0 = 4'd9;
  localparam logic [3:0] codeOvflw1 = 4'd10;
  localparam logic [3:0] codeRoAcc = 4'd11;
  localparam logic [3:0] codeRoTat = 4'd12;
  localparam logic [3:0] codeInvalid = 4'd13;
  localparam int maxEntries = 64;
  localparam int waitLimit = 200;
  localparam int poolWords = 40;

  logic clk;
  logic rst;
  logic [wordWidth-1:0] bdData;
  logic bdValid;
  logic bdReady;
  logic [recordWidth-1:0] logData;
  logic logValid;
  logic logPop;
  logic [countWidth-1:0] invalidCount;
  logic [countWidth-1:0] tagCount;
  logic [countWidth-1:0] ovflwCount0;
  logic [countWidth-1:0] ovflwCount1;

  // stimulus table with one row per file line
  int entryCount = 0;
  int testId [maxEntries];
  logic [wordWidth-1:0] wordMem [maxEntries];
  logic [codeWidth-1:0] codeMem [maxEntries];
  logic [payloadWidth-1:0] payMem [maxEntries];
  bit logMem [maxEntries];
  int poolIdx [$];

  // expected records per writer class
  logic [recordWidth-1:0] tagQueue [$];
  logic [recordWidth-1:0] diagQueue [$];
  int expTag = 0;
  int expOv0 = 0;
  int expOv1 = 0;
  int expInvalid = 0;

  int errors = 0;
  int testStart = 0;
  int testsRun = 0;
  int recordsChecked = 0;
  int accepted = 0;
  int acceptedBase = 0;
  integer seed = 32'h62a9_579f;
  logic [31:0] coin;
  bit popEnable = 1'b0;

  clockGen u_clockGen (.clk(clk), .rst(rst));

  bdReadout u_bdReadout (
    .clk(clk), .rst(rst),
    .bdData(bdData), .bdValid(bdValid), .bdReady(bdReady),
    .logData(logData), .logValid(logValid), .logPop(logPop),
    .invalidCount(invalidCount), .tagCount(tagCount),
    .ovflwCount0(ovflwCount0), .ovflwCount1(ovflwCount1)
  );

  ////////////////////////////////////////
  // reporting

  function automatic bit isTagCode(input logic [codeWidth-1:0] code);
    return (code == codeNrni) || (code == codeRoAcc) || (code == codeRoTat);
  endfunction

  task automatic reportMismatch(input string name, input logic [recordWidth-1:0] expVal,
                                input logic [recordWidth-1:0] gotVal);
    errors++;
    $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expVal, gotVal);
  endtask

  task automatic reportError(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic printSummary();
    $display("summary: %0d tests, %0d records checked, %0d errors",
             testsRun, recordsChecked, errors);
  endtask

  // stuck handshake ends the run
  task automatic abortRun(input string why);
    reportError(why);
    printSummary();
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic startTest();
    testStart = errors;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    $display("test %s: %0d errors", name, errors - testStart);
  endtask

  ////////////////////////////////////////
  // stimulus

  // columns are test id, word, leaf code, payload and logged flag
  task automatic loadStimulus();
    int fd;
    int got;
    int t;
    int flag;
    logic [wordWidth-1:0] word;
    logic [codeWidth-1:0] code;
    logic [payloadWidth-1:0] pay;
    fd = $fopen("bench/bdReadoutInput.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open bench/bdReadoutInput.txt");
    end else begin
      got = 5;
      while (got == 5 && !$feof(fd) && entryCount < maxEntries) begin
        got = $fscanf(fd, "%d %h %h %h %d\n", t, word, code, pay, flag);
        if (got == 5) begin
          testId[entryCount] = t;
          wordMem[entryCount] = word;
          codeMem[entryCount] = code;
          payMem[entryCount] = pay;
          logMem[entryCount] = (flag != 0);
          entryCount++;
        end
      end
      $fclose(fd);
      if (entryCount == 0) abortRun("stimulus file holds no entries");
    end
  endtask

  task automatic waitResetDone();
    int waited;
    waited = 0;
    @(posedge clk);
    while (rst && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (rst) begin
      abortRun("reset never released");
    end else begin
      #1;
    end
  endtask

  // word held until bdReady and one transfer edge
  task automatic sendWord(input logic [wordWidth-1:0] word);
    int waited;
    waited = 0;
    bdData = word;
    bdValid = 1'b1;
    while (!bdReady && waited < waitLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!bdReady) begin
      abortRun("bdReady stayed low for 200 cycles");
    end else begin
      @(posedge clk);
      #1;
      bdValid = 1'b0;
      accepted++;
    end
  endtask

  // expectations queued before the word goes out
  task automatic sendEntry(input int idx);
    logic [codeWidth-1:0] code;
    code = codeMem[idx];
    if (logMem[idx]) begin
      if (isTagCode(code)) tagQueue.push_back({code, payMem[idx]});
      else diagQueue.push_back({code, payMem[idx]});
    end
    if (isTagCode(code)) expTag++;
    if (code == codeOvflw0) expOv0++;
    if (code == codeOvflw1) expOv1++;
    if (code == codeInvalid) expInvalid++;
    sendWord(wordMem[idx]);
  endtask

  task automatic runTest(input int id);
    for (int i = 0; i < entryCount; i++) begin
      if (testId[i] == id) sendEntry(i);
    end
  endtask

  // reuses the pool round robin
  task automatic sendPool(input int count);
    for (int i = 0; i < count; i++) begin
      sendEntry(poolIdx[i % poolIdx.size()]);
    end
  endtask

  ////////////////////////////////////////
  // log side

  task automatic compareRecord(input logic [recordWidth-1:0] expRec,
                               input logic [recordWidth-1:0] rec);
    if (rec[recordWidth-1:payloadWidth] !== expRec[recordWidth-1:payloadWidth])
      reportMismatch("logData code", expRec[recordWidth-1:payloadWidth],
                     rec[recordWidth-1:payloadWidth]);
    if (rec[payloadWidth-1:0] !== expRec[payloadWidth-1:0])
      reportMismatch("logData payload", expRec[payloadWidth-1:0], rec[payloadWidth-1:0]);
  endtask

  // popped code picks the class queue
  task automatic checkRecord(input logic [recordWidth-1:0] rec);
    logic [recordWidth-1:0] expRec;
    recordsChecked++;
    if (isTagCode(rec[recordWidth-1:payloadWidth])) begin
      if (tagQueue.size() == 0) begin
        reportError($sformatf("unexpected tag record %0h in the log", rec));
      end else begin
        expRec = tagQueue.pop_front();
        compareRecord(expRec, rec);
      end
    end else begin
      if (diagQueue.size() == 0) begin
        reportError($sformatf("unexpected diagnostic record %0h in the log", rec));
      end else begin
        expRec = diagQueue.pop_front();
        compareRecord(expRec, rec);
      end
    end
  endtask

  // host model popping about three cycles in four
  initial begin
    logPop = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      coin = $random(seed);
      if (popEnable && logValid && coin[1:0] != 2'b00) begin
        logPop = 1'b1;
        checkRecord(logData);
      end else begin
        logPop = 1'b0;
      end
    end
  end

  // timeout restarts with every record that arrives
  task automatic drainLog();
    int waited;
    int left;
    waited = 0;
    left = tagQueue.size() + diagQueue.size();
    while (left != 0 && waited < waitLimit) begin
      @(posedge clk);
      #1;
      if ((tagQueue.size() + diagQueue.size()) < left) waited = 0;
      else waited++;
      left = tagQueue.size() + diagQueue.size();
    end
    if (left != 0)
      abortRun($sformatf("log drain timed out, %0d records never arrived", left));
  endtask

  // counters can trail the last record by a cycle or two
  task automatic checkCounts();
    int waited;
    waited = 0;
    while ((tagCount != expTag || ovflwCount0 != expOv0 || ovflwCount1 != expOv1 ||
            invalidCount != expInvalid) && waited < waitLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (tagCount != expTag) reportMismatch("tagCount", expTag, tagCount);
    if (ovflwCount0 != expOv0) reportMismatch("ovflwCount0", expOv0, ovflwCount0);
    if (ovflwCount1 != expOv1) reportMismatch("ovflwCount1", expOv1, ovflwCount1);
    if (invalidCount != expInvalid) reportMismatch("invalidCount", expInvalid, invalidCount);
  endtask

  // stall seen once the fifo and the writer buffers are full
  task automatic watchStall(input int base);
    int lowCycles;
    int waited;
    lowCycles = 0;
    waited = 0;
    while (lowCycles < 20 && waited < waitLimit) begin
      @(posedge clk);
      #1;
      waited++;
      if (!bdReady) lowCycles++;
      else lowCycles = 0;
    end
    if (lowCycles < 20) reportError("bdReady never fell while the log was not popped");
    if (accepted - base <= logDepth) reportError("bdReady fell before the log was full");
    if (!logValid) reportError("logValid low while the input was stalled");
    popEnable = 1'b1;
  endtask

  task automatic checkLogIdle();
    int waited;
    waited = 0;
    while (!logValid && waited < 20) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (logValid) reportError("extra record in the log after all expected ones");
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    bdData = '0;
    bdValid = 1'b0;
    loadStimulus();
    waitResetDone();

    // state straight out of reset
    startTest();
    if (logValid !== 1'b0) reportMismatch("logValid", 0, logValid);
    if (invalidCount !== '0) reportMismatch("invalidCount", 0, invalidCount);
    if (tagCount !== '0) reportMismatch("tagCount", 0, tagCount);
    if (ovflwCount0 !== '0) reportMismatch("ovflwCount0", 0, ovflwCount0);
    if (ovflwCount1 !== '0) reportMismatch("ovflwCount1", 0, ovflwCount1);
    finishTest("6 reset state");

    popEnable = 1'b1;
    startTest();
    runTest(1);
    drainLog();
    checkCounts();
    checkLogIdle();
    finishTest("1 leaf decode");

    // routes cover every prefix so no word counts as invalid
    startTest();
    runTest(2);
    drainLog();
    checkCounts();
    finishTest("2 invalid words");

    // repeated warnings must not reach the log
    startTest();
    runTest(3);
    drainLog();
    checkCounts();
    checkLogIdle();
    finishTest("3 overflow warnings");

    startTest();
    runTest(4);
    drainLog();
    checkCounts();
    checkLogIdle();
    finishTest("4 mixed traffic");

    // pool of loggable words from the mixed test
    startTest();
    popEnable = 1'b0;
    for (int i = 0; i < entryCount; i++) begin
      if (testId[i] == 4 && logMem[i] && codeMem[i] != codeOvflw0 && codeMem[i] != codeOvflw1)
        poolIdx.push_back(i);
    end
    if (poolIdx.size() == 0) begin
      reportError("no loggable words for the back-pressure test");
    end else begin
      acceptedBase = accepted;
      fork
        sendPool(poolWords);
        watchStall(acceptedBase);
      join
    end
    drainLog();
    checkCounts();
    checkLogIdle();
    finishTest("5 back-pressure");

    printSummary();
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    // released just after the edge, like every other input
    #1;
    rst = 1'b0;
  end

endmodule

// ==== verilog/bdReadout.sv ====
`timescale 1ns/1ps

module bdReadout (
  input  logic clk,
  input  logic rst,
  input  bdPkg::bdWord bdData,
  input  logic bdValid,
  output logic bdReady,
  output logic [bdPkg::recordWidth-1:0] logData,
  output logic logValid,
  input  logic logPop,
  output logic [bdPkg::countWidth-1:0] invalidCount,
  output logic [bdPkg::countWidth-1:0] tagCount,
  output logic [bdPkg::countWidth-1:0] ovflwCount0,
  output logic [bdPkg::countWidth-1:0] ovflwCount1
);
  import bdPkg::*;

  // decoder to writers
  leafCode tagCode;
  logic [payloadWidth-1:0] tagPayload;
  logic tagValid;
  logic tagReady;
  leafCode diagCode;
  logic [payloadWidth-1:0] diagPayload;
  logic diagValid;
  logic diagReady;

  // writers to arbiter
  logic tagReq;
  logic tagGrant;
  logic [recordWidth-1:0] tagRecord;
  logic diagReq;
  logic diagGrant;
  logic [recordWidth-1:0] diagRecord;

  // arbiter to log
  logic fifoFull;
  logic fifoWrite;
  logic [recordWidth-1:0] fifoRecord;

  ////////////////////////////////////////
  // datapath

  bdDecoder u_bdDecoder (
    .clk(clk), .rst(rst),
    .bdData(bdData), .bdValid(bdValid), .bdReady(bdReady),
    .tagCode(tagCode), .tagPayload(tagPayload),
    .tagValid(tagValid), .tagReady(tagReady),
    .diagCode(diagCode), .diagPayload(diagPayload),
    .diagValid(diagValid), .diagReady(diagReady),
    .invalidCount(invalidCount)
  );

  tagWriter u_tagWriter (
    .clk(clk), .rst(rst),
    .tagCode(tagCode), .tagPayload(tagPayload),
    .tagValid(tagValid), .tagReady(tagReady),
    .tagReq(tagReq), .tagRecord(tagRecord), .tagGrant(tagGrant),
    .tagCount(tagCount)
  );

  diagWriter u_diagWriter (
    .clk(clk), .rst(rst),
    .diagCode(diagCode), .diagPayload(diagPayload),
    .diagValid(diagValid), .diagReady(diagReady),
    .diagReq(diagReq), .diagRecord(diagRecord), .diagGrant(diagGrant),
    .ovflwCount0(ovflwCount0), .ovflwCount1(ovflwCount1)
  );

  // shared log
  logArbiter u_logArbiter (
    .clk(clk), .rst(rst),
    .tagReq(tagReq), .tagRecord(tagRecord), .tagGrant(tagGrant),
    .diagReq(diagReq), .diagRecord(diagRecord), .diagGrant(diagGrant),
    .fifoFull(fifoFull), .fifoWrite(fifoWrite), .fifoRecord(fifoRecord)
  );

  logFifo u_logFifo (
    .clk(clk), .rst(rst),
    .fifoWrite(fifoWrite), .fifoRecord(fifoRecord), .fifoFull(fifoFull),
    .logPop(logPop), .logData(logData), .logValid(logValid)
  );

endmodule

// ==== verilog/logFifo.sv ====
`timescale 1ns/1ps

module logFifo (
  input  logic clk,
  input  logic rst,
  input  logic fifoWrite,
  input  logic [bdPkg::recordWidth-1:0] fifoRecord,
  output logic fifoFull,
  input  logic logPop,
  output logic [bdPkg::recordWidth-1:0] logData,
  output logic logValid
);
  import bdPkg::*;

  logic [recordWidth-1:0] mem [logDepth];
  logic [logPtrWidth-1:0] wrPtr;
  logic [logPtrWidth-1:0] rdPtr;
  // occupancy includes the head register
  logic [logCountWidth-1:0] fill;
  logic pop;
  logic load;
  logic memEmpty;

  assign pop = logPop && logValid;
  assign memEmpty = (fill == logCountWidth'(logValid));
  // refill head when it is empty or leaving
  assign load = !memEmpty && (!logValid || pop);
  assign fifoFull = (fill == logCountWidth'(logDepth));

  ////////////////////////////////////////
  // pointers and count

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
      logValid <= 1'b0;
    end else begin
      if (fifoWrite) wrPtr <= wrPtr + 1'b1;
      if (load) rdPtr <= rdPtr + 1'b1;
      case ({fifoWrite, pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      if (load) begin
        logValid <= 1'b1;
      end else if (pop) begin
        logValid <= 1'b0;
      end
    end
  end

  // storage and head record
  always_ff @(posedge clk) begin
    if (fifoWrite) mem[wrPtr] <= fifoRecord;
    if (load) logData <= mem[rdPtr];
  end

endmodule

// ==== verilog/logArbiter.sv ====
`timescale 1ns/1ps

module logArbiter (
  input  logic clk,
  input  logic rst,
  input  logic tagReq,
  input  logic [bdPkg::recordWidth-1:0] tagRecord,
  output logic tagGrant,
  input  logic diagReq,
  input  logic [bdPkg::recordWidth-1:0] diagRecord,
  output logic diagGrant,
  input  logic fifoFull,
  output logic fifoWrite,
  output logic [bdPkg::recordWidth-1:0] fifoRecord
);
  import bdPkg::*;

  // set when the tag side won last
  logic lastTag;

  ////////////////////////////////////////
  // grant select

  always_comb begin
    tagGrant = 1'b0;
    diagGrant = 1'b0;
    // nothing moves while the log is full
    if (!fifoFull) begin
      if (tagReq && diagReq) begin
        // contention goes to whoever lost last time
        if (lastTag) diagGrant = 1'b1;
        else tagGrant = 1'b1;
      end else begin
        tagGrant = tagReq;
        diagGrant = diagReq;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lastTag <= 1'b0;
    end else if (tagGrant) begin
      lastTag <= 1'b1;
    end else if (diagGrant) begin
      lastTag <= 1'b0;
    end
  end

  // write port mux
  assign fifoWrite = tagGrant || diagGrant;
  assign fifoRecord = diagGrant ? diagRecord : tagRecord;

endmodule

// ==== verilog/diagWriter.sv ====
`timescale 1ns/1ps

module diagWriter (
  input  logic clk,
  input  logic rst,
  input  bdPkg::leafCode diagCode,
  input  logic [bdPkg::payloadWidth-1:0] diagPayload,
  input  logic diagValid,
  output logic diagReady,
  output logic diagReq,
  output logic [bdPkg::recordWidth-1:0] diagRecord,
  input  logic diagGrant,
  output logic [bdPkg::countWidth-1:0] ovflwCount0,
  output logic [bdPkg::countWidth-1:0] ovflwCount1
);
  import bdPkg::*;

  logic held;
  logic accept;
  logic pop;
  logic isOv0;
  logic isOv1;
  logic repeatWarn;
  logic keep;

  ////////////////////////////////////////
  // handshake

  assign pop = diagReq && diagGrant;
  // slot frees in the same cycle it drains
  assign diagReady = !held || pop;
  assign accept = diagValid && diagReady;
  assign diagReq = held;

  // warning classes
  assign isOv0 = (diagCode == OVFLW0);
  assign isOv1 = (diagCode == OVFLW1);

  // later warnings of a class only bump the counter
  assign repeatWarn = (isOv0 && ovflwCount0 != '0) || (isOv1 && ovflwCount1 != '0);
  assign keep = accept && !repeatWarn;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
      ovflwCount0 <= '0;
      ovflwCount1 <= '0;
    end else begin
      if (keep) begin
        held <= 1'b1;
      end else if (pop) begin
        held <= 1'b0;
      end
      if (accept && isOv0) ovflwCount0 <= ovflwCount0 + 1'b1;
      if (accept && isOv1) ovflwCount1 <= ovflwCount1 + 1'b1;
    end
  end

  ////////////////////////////////////////
  // record slot

  // dumps pass through untouched
  always_ff @(posedge clk) begin
    if (keep) diagRecord <= {diagCode, diagPayload};
  end

endmodule

// ==== verilog/tagWriter.sv ====
`timescale 1ns/1ps

module tagWriter (
  input  logic clk,
  input  logic rst,
  input  bdPkg::leafCode tagCode,
  input  logic [bdPkg::payloadWidth-1:0] tagPayload,
  input  logic tagValid,
  output logic tagReady,
  output logic tagReq,
  output logic [bdPkg::recordWidth-1:0] tagRecord,
  input  logic tagGrant,
  output logic [bdPkg::countWidth-1:0] tagCount
);
  import bdPkg::*;

  // two record slots, used as a tiny ring
  logic [recordWidth-1:0] slot [2];
  logic wrSel;
  logic rdSel;
  logic [1:0] fill;
  logic push;
  logic pop;

  assign tagReady = (fill != 2'd2);
  assign tagReq = (fill != 2'd0);
  assign tagRecord = slot[rdSel];
  assign push = tagValid && tagReady;
  assign pop = tagReq && tagGrant;

  always_ff @(posedge clk) begin
    if (rst) begin
      wrSel <= 1'b0;
      rdSel <= 1'b0;
      fill <= 2'd0;
      tagCount <= '0;
    end else begin
      if (push) wrSel <= ~wrSel;
      if (pop) rdSel <= ~rdSel;
      case ({push, pop})
        2'b10: fill <= fill + 2'd1;
        2'b01: fill <= fill - 2'd1;
        default: fill <= fill;
      endcase
      // one count per record handed to the log
      if (pop) tagCount <= tagCount + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) slot[wrSel] <= {tagCode, tagPayload};
  end

endmodule

// ==== verilog/bdDecoder.sv ====
`timescale 1ns/1ps

module bdDecoder (
  input  logic clk,
  input  logic rst,
  input  bdPkg::bdWord bdData,
  input  logic bdValid,
  output logic bdReady,
  output bdPkg::leafCode tagCode,
  output logic [bdPkg::payloadWidth-1:0] tagPayload,
  output logic tagValid,
  input  logic tagReady,
  output bdPkg::leafCode diagCode,
  output logic [bdPkg::payloadWidth-1:0] diagPayload,
  output logic diagValid,
  input  logic diagReady,
  output logic [bdPkg::countWidth-1:0] invalidCount
);
  import bdPkg::*;

  logic [leafCount-1:0] hit;
  leafCode leaf;
  logic [wordWidth-1:0] keepMask;
  logic [wordWidth-1:0] masked;
  logic [payloadWidth-1:0] payload;
  logic isTag;

  // stage state
  logic live;
  logic stageFull;
  logic stageTag;
  leafCode stageCode;
  logic [payloadWidth-1:0] stagePayload;
  logic load;
  logic leave;

  ////////////////////////////////////////
  // route match

  // all prefixes compared at once
  always_comb begin
    for (int i = 0; i < leafCount; i++) begin
      hit[i] = ((bdData & routeMask[i]) == routeTable[i]);
    end
  end

  // walk backwards so the earliest table entry wins
  always_comb begin
    leaf = INVALID;
    keepMask = '0;
    for (int i = leafCount - 1; i >= 0; i--) begin
      if (hit[i]) begin
        leaf = leafCode'(i);
        keepMask = ~routeMask[i];
      end
    end
  end

  assign masked = bdData & keepMask;

  // short and long views give the payload directly
  always_comb begin
    case (leaf)
      NRNI, RO_ACC, RO_TAT: payload = bdData.shortView.payload;
      OVFLW0, OVFLW1: payload = payloadWidth'(bdData.longView.rest);
      default: payload = masked[payloadWidth-1:0];
    endcase
  end

  assign isTag = (leaf == NRNI) || (leaf == RO_ACC) || (leaf == RO_TAT);

  ////////////////////////////////////////
  // output stage

  assign tagValid = stageFull && stageTag;
  assign diagValid = stageFull && !stageTag;
  assign leave = (tagValid && tagReady) || (diagValid && diagReady);
  // ready held low for the first cycle out of reset
  assign bdReady = live && (!stageFull || leave);
  assign load = bdValid && bdReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      live <= 1'b0;
      stageFull <= 1'b0;
      invalidCount <= '0;
    end else begin
      live <= 1'b1;
      // invalid words vanish here
      if (load) begin
        stageFull <= (leaf != INVALID);
      end else if (leave) begin
        stageFull <= 1'b0;
      end
      if (load && leaf == INVALID) begin
        invalidCount <= invalidCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      stageCode <= leaf;
      stagePayload <= payload;
      stageTag <= isTag;
    end
  end

  // both writers see the same word, valid picks the owner
  assign tagCode = stageCode;
  assign tagPayload = stagePayload;
  assign diagCode = stageCode;
  assign diagPayload = stagePayload;

endmodule

// ==== verilog/bdPkg.sv ====
package bdPkg;

  ////////////////////////////////////////
  // widths

  localparam int wordWidth = 34;
  localparam int payloadWidth = 32;
  localparam int leafCount = 13;
  localparam int codeWidth = 4;
  localparam int recordWidth = codeWidth + payloadWidth;
  localparam int countWidth = 16;

  // log fifo sizing
  localparam int logDepth = 32;
  localparam int logPtrWidth = $clog2(logDepth);
  localparam int logCountWidth = $clog2(logDepth + 1);

  // route field widths of the two word views
  localparam int shortRouteWidth = 2;
  localparam int longRouteWidth = 7;

  ////////////////////////////////////////
  // leaves, value is the record code

  typedef enum logic [codeWidth-1:0] {
    DUMP_AM = 4'd0,
    DUMP_MM,
    DUMP_PAT,
    DUMP_POST_FIFO0,
    DUMP_POST_FIFO1,
    DUMP_PRE_FIFO,
    DUMP_TAT0,
    DUMP_TAT1,
    NRNI,
    OVFLW0,
    OVFLW1,
    RO_ACC,
    RO_TAT,
    INVALID
  } leafCode;

  // routes left-aligned in the word, same order as leafCode
  localparam logic [0:leafCount-1][wordWidth-1:0] routeTable = '{
    {6'b101000, {(wordWidth-6){1'b0}}},
    {6'b101001, {(wordWidth-6){1'b0}}},
    {5'b10101, {(wordWidth-5){1'b0}}},
    {6'b101110, {(wordWidth-6){1'b0}}},
    {6'b101111, {(wordWidth-6){1'b0}}},
    {6'b101101, {(wordWidth-6){1'b0}}},
    {4'b1000, {(wordWidth-4){1'b0}}},
    {4'b1001, {(wordWidth-4){1'b0}}},
    {2'b11, {(wordWidth-2){1'b0}}},
    {7'b1011000, {(wordWidth-7){1'b0}}},
    {7'b1011001, {(wordWidth-7){1'b0}}},
    {2'b01, {(wordWidth-2){1'b0}}},
    {2'b00, {(wordWidth-2){1'b0}}}
  };

  // prefix masks, one bit per route bit
  localparam logic [0:leafCount-1][wordWidth-1:0] routeMask = '{
    {{6{1'b1}}, {(wordWidth-6){1'b0}}},
    {{6{1'b1}}, {(wordWidth-6){1'b0}}},
    {{5{1'b1}}, {(wordWidth-5){1'b0}}},
    {{6{1'b1}}, {(wordWidth-6){1'b0}}},
    {{6{1'b1}}, {(wordWidth-6){1'b0}}},
    {{6{1'b1}}, {(wordWidth-6){1'b0}}},
    {{4{1'b1}}, {(wordWidth-4){1'b0}}},
    {{4{1'b1}}, {(wordWidth-4){1'b0}}},
    {{2{1'b1}}, {(wordWidth-2){1'b0}}},
    {{7{1'b1}}, {(wordWidth-7){1'b0}}},
    {{7{1'b1}}, {(wordWidth-7){1'b0}}},
    {{2{1'b1}}, {(wordWidth-2){1'b0}}},
    {{2{1'b1}}, {(wordWidth-2){1'b0}}}
  };

  ////////////////////////////////////////
  // funnel word views

  // tag leaves, 2-bit route over the full payload
  typedef struct packed {
    logic [shortRouteWidth-1:0] route;
    logic [payloadWidth-1:0] payload;
  } shortRouteView;

  // overflow leaves, 7-bit route field
  typedef struct packed {
    logic [longRouteWidth-1:0] route;
    logic [wordWidth-longRouteWidth-1:0] rest;
  } longRouteView;

  typedef union packed {
    shortRouteView shortView;
    longRouteView longView;
  } bdWord;

endpackage
